// ==== mont_mul_serial.sv ====
`timescale 1ns/10ps
// ------------------------------
// Bit-serial Montgomery multiply
// R = 2**DATA_W
// ------------------------------
module mont_mul_serial #(
    parameter int DATA_W = 32
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              start_i,
    input  logic              square_i,
    input  logic [DATA_W-1:0] twiddle_i,
    input  logic [DATA_W-1:0] omega_i,
    input  logic [DATA_W-1:0] prime_i,
    output logic              done_o,
    output logic [DATA_W-1:0] result_o
);

    localparam int CNT_W = $clog2(DATA_W);

    logic [DATA_W-1:0] a_q;
    logic [DATA_W-1:0] b_q;
    logic [DATA_W+1:0] acc_q;
    logic [DATA_W+1:0] acc_add;
    logic [DATA_W+1:0] acc_red;
    logic [DATA_W+1:0] prime_ext;
    logic [CNT_W-1:0]  cnt_q;
    logic              busy_q;
    logic              done_q;

    assign prime_ext = {2'b00, prime_i};

    // One step: add b on a bit, make even, halve
    assign acc_add = acc_q + (a_q[0] ? {2'b00, b_q} : '0);
    assign acc_red = acc_add[0] ? acc_add + prime_ext : acc_add;

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            a_q   <= square_i ? omega_i : twiddle_i;
            b_q   <= omega_i;
            acc_q <= '0;
        end else if (busy_q) begin
            a_q   <= a_q >> 1;
            acc_q <= acc_red >> 1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (start_i) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (busy_q) begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == CNT_W'(DATA_W - 1)) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    // Accumulator is below 2p, one subtraction reduces it
    assign result_o = (acc_q >= prime_ext) ? DATA_W'(acc_q - prime_ext) : acc_q[DATA_W-1:0];
    assign done_o   = done_q;

    a_no_start_when_busy: assert property (
        @(posedge clk_i) disable iff (!rst_ni) start_i |-> !busy_q
    );

endmodule

// ==== root_index_counters.sv ====
`timescale 1ns/10ps
// ------------------------------
// Omega and psi index counters
// ------------------------------
module root_index_counters
    import twiddle_pkg::*;
#(
    parameter int DATA_W = twiddle_pkg::DATA_W
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    twiddle_ctrl_if.idx      ctrl_i,
    output logic [IDX_W-1:0] omega_idx_o,
    output logic [IDX_W-1:0] psi_idx_o
);

    logic [IDX_W-1:0] omega_idx_q;
    logic [IDX_W-1:0] psi_idx_q;
    logic             omega_ld;
    logic             psi_ld;
    logic             omega_inc;
    logic             psi_inc;

    assign omega_ld  = ctrl_i.wr_en && (ctrl_i.addr == ADDR_OMEGA_IDX);
    assign psi_ld    = ctrl_i.wr_en && (ctrl_i.addr == ADDR_PSI_IDX);
    assign omega_inc = ctrl_i.op_commit && (ctrl_i.op == OP_OMEGA_IDX_INC);
    assign psi_inc   = ctrl_i.op_commit && (ctrl_i.op == OP_PSI_IDX_INC);

    // Increment wraps 7 -> 0 by width
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            omega_idx_q <= '0;
            psi_idx_q   <= '0;
        end else begin
            if (omega_ld) begin
                omega_idx_q <= ctrl_i.wdata[IDX_W-1:0];
            end else if (omega_inc) begin
                omega_idx_q <= omega_idx_q + 1'b1;
            end
            if (psi_ld) begin
                psi_idx_q <= ctrl_i.wdata[IDX_W-1:0];
            end else if (psi_inc) begin
                psi_idx_q <= psi_idx_q + 1'b1;
            end
        end
    end

    always_comb begin
        ctrl_i.rd_idx = '0;
        if (ctrl_i.addr == ADDR_OMEGA_IDX) begin
            ctrl_i.rd_idx = DATA_W'(omega_idx_q);
        end else if (ctrl_i.addr == ADDR_PSI_IDX) begin
            ctrl_i.rd_idx = DATA_W'(psi_idx_q);
        end
    end

    assign omega_idx_o = omega_idx_q;
    assign psi_idx_o   = psi_idx_q;

    a_no_load_with_inc: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !((omega_ld && omega_inc) || (psi_ld && psi_inc))
    );

endmodule

// ==== root_table.sv ====
`timescale 1ns/10ps
// ------------------------------
// Omega and psi root tables
// ------------------------------
module root_table
    import twiddle_pkg::*;
#(
    parameter int DATA_W    = twiddle_pkg::DATA_W,
    parameter int NUM_ROOTS = twiddle_pkg::NUM_ROOTS
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    twiddle_ctrl_if.tbl       ctrl_i,
    input  logic [IDX_W-1:0]  omega_idx_i,
    input  logic [IDX_W-1:0]  psi_idx_i,
    output logic [DATA_W-1:0] omega_o,
    output logic [DATA_W-1:0] psi_o
);

    logic [DATA_W-1:0]    omega_q [NUM_ROOTS];
    logic [DATA_W-1:0]    psi_q   [NUM_ROOTS];
    logic [NUM_ROOTS-1:0] omega_oh;
    logic [NUM_ROOTS-1:0] psi_oh;
    logic [IDX_W-1:0]     omega_word;
    logic [IDX_W-1:0]     psi_word;
    logic                 in_omega;
    logic                 in_psi;
    logic                 omega_sqr;
    logic                 psi_copy;

    // Bus address to table word
    assign in_omega   = (ctrl_i.addr >= ADDR_OMEGA_BASE)
                     && (ctrl_i.addr < ADDR_OMEGA_BASE + NUM_ROOTS);
    assign in_psi     = (ctrl_i.addr >= ADDR_PSI_BASE)
                     && (ctrl_i.addr < ADDR_PSI_BASE + NUM_ROOTS);
    assign omega_word = IDX_W'(ctrl_i.addr - ADDR_OMEGA_BASE);
    assign psi_word   = IDX_W'(ctrl_i.addr - ADDR_PSI_BASE);

    // One-hot word select for operations
    assign omega_oh  = NUM_ROOTS'(1) << omega_idx_i;
    assign psi_oh    = NUM_ROOTS'(1) << psi_idx_i;
    assign omega_sqr = ctrl_i.op_commit && (ctrl_i.op == OP_OMEGA_SQR);
    assign psi_copy  = ctrl_i.op_commit && (ctrl_i.op == OP_PSI_FROM_OMEGA);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < NUM_ROOTS; i++) begin
                omega_q[i] <= '0;
                psi_q[i]   <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_ROOTS; i++) begin
                if (ctrl_i.wr_en && in_omega && omega_word == i) begin
                    omega_q[i] <= ctrl_i.wdata;
                end else if (omega_sqr && omega_oh[i]) begin
                    omega_q[i] <= ctrl_i.mul_result;
                end
                if (ctrl_i.wr_en && in_psi && psi_word == i) begin
                    psi_q[i] <= ctrl_i.wdata;
                end else if (psi_copy && psi_oh[i]) begin
                    psi_q[i] <= omega_o;
                end
            end
        end
    end

    assign omega_o = omega_q[omega_idx_i];
    assign psi_o   = psi_q[psi_idx_i];

    always_comb begin
        ctrl_i.rd_table = '0;
        if (in_omega) begin
            ctrl_i.rd_table = omega_q[omega_word];
        end else if (in_psi) begin
            ctrl_i.rd_table = psi_q[psi_word];
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the twiddle unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_twiddle_unit \
    -f twiddle_unit.f > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vtb_twiddle_unit > sim.log 2>&1 || { cat sim.log; echo "Simulation aborted"; exit 1; }
cat sim.log
grep -q "TB FAILED" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
exit 0

// ==== tb_twiddle_unit.sv ====
`timescale 1ns/10ps
// ------------------------------
// Twiddle unit testbench
// Bus tasks, model and checks
// ------------------------------
module tb_twiddle_unit
    import twiddle_pkg::*;
();

    localparam int ACK_TIMEOUT = 100;
    localparam int RAND_STEPS  = 200;

    logic        clk;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [4:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic [31:0] twiddle_o;
    logic [31:0] omega_o;
    logic [31:0] psi_o;
    logic [31:0] prime_o;

    // Model of the register file
    logic [31:0] m_prime;
    logic [31:0] m_twiddle;
    logic [31:0] m_omega [8];
    logic [31:0] m_psi   [8];
    logic [2:0]  m_oidx;
    logic [2:0]  m_pidx;

    logic [31:0] lcg_state;
    logic        hung;
    int          err_total;
    int          test_errs;
    int          tests_run;
    int          tests_failed;

    twiddle_unit_top #(
        .DATA_W   (32),
        .NUM_ROOTS(8)
    ) i_dut (
        .clk_i    (clk),
        .rst_ni   (rst_n),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_dat_o (wb_dat_r),
        .wb_ack_o (wb_ack),
        .twiddle_o(twiddle_o),
        .omega_o  (omega_o),
        .psi_o    (psi_o),
        .prime_o  (prime_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Odd prime candidate in [2**30, 2**31)
    function automatic logic [31:0] rand_prime();
        logic [31:0] r;
        r = next_rand();
        return {2'b01, r[29:1], 1'b1};
    endfunction

    // Radix-2 Montgomery product a*b/2**32 mod p with a final subtraction
    function automatic logic [31:0] ref_mont(input logic [31:0] a, input logic [31:0] b,
                                             input logic [31:0] p);
        logic [63:0] acc;
        acc = '0;
        for (int i = 0; i < 32; i++) begin
            if (a[i])
                acc = acc + b;
            if (acc[0])
                acc = acc + p;
            acc = acc >> 1;
        end
        if (acc >= p)
            acc = acc - p;
        return acc[31:0];
    endfunction

    function automatic logic [31:0] exp_read(input logic [4:0] adr);
        logic [31:0] val;
        val = '0;
        if (adr == ADDR_PRIME)
            val = m_prime;
        else if (adr == ADDR_TWIDDLE)
            val = m_twiddle;
        else if (adr == ADDR_OMEGA_IDX)
            val = 32'(m_oidx);
        else if (adr == ADDR_PSI_IDX)
            val = 32'(m_pidx);
        else if (adr >= ADDR_OMEGA_BASE && adr < ADDR_OMEGA_BASE + 8)
            val = m_omega[adr[2:0]];
        else if (adr >= ADDR_PSI_BASE && adr < ADDR_PSI_BASE + 8)
            val = m_psi[adr[2:0]];
        return val;
    endfunction

    task automatic bus_access(input logic we, input logic [4:0] adr, input logic [31:0] wdat,
                              output logic [31:0] rdat);
        int   waited;
        logic got_ack;
        logic mul_cmd;
        rdat = '0;
        if (hung)
            return;
        mul_cmd  = we && (adr == ADDR_CMD)
                   && (wdat[2:0] == OP_TW_MUL || wdat[2:0] == OP_OMEGA_SQR);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        waited   = 0;
        got_ack  = 1'b0;
        while (!got_ack && waited < ACK_TIMEOUT) begin
            @(posedge clk);
            #1;
            got_ack = wb_ack;
            waited++;
        end
        rdat = wb_dat_r;
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        if (!got_ack) begin
            $display("Bus access to address %0d got no ack within %0d cycles", adr, ACK_TIMEOUT);
            hung = 1'b1;
            err_total++;
            test_errs++;
            return;
        end
        // Single-cycle accesses ack on the first edge
        if (!mul_cmd && waited != 1) begin
            $display("Ack for address %0d came after %0d cycles, not 1", adr, waited);
            err_total++;
            test_errs++;
        end
        // Multiply results commit one edge after ack
        @(posedge clk);
        #2;
        if (wb_ack) begin
            $display("Ack for address %0d stayed high for more than one cycle", adr);
            err_total++;
            test_errs++;
        end
    endtask

    task automatic wb_write(input logic [4:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        bus_access(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [4:0] adr, output logic [31:0] data);
        bus_access(1'b0, adr, '0, data);
    endtask

    task automatic reg_write(input logic [4:0] adr, input logic [31:0] data);
        wb_write(adr, data);
        if (adr == ADDR_PRIME)
            m_prime = data;
        else if (adr == ADDR_TWIDDLE)
            m_twiddle = data;
        else if (adr == ADDR_OMEGA_IDX)
            m_oidx = data[2:0];
        else if (adr == ADDR_PSI_IDX)
            m_pidx = data[2:0];
        else if (adr >= ADDR_OMEGA_BASE && adr < ADDR_OMEGA_BASE + 8)
            m_omega[adr[2:0]] = data;
        else if (adr >= ADDR_PSI_BASE && adr < ADDR_PSI_BASE + 8)
            m_psi[adr[2:0]] = data;
    endtask

    task automatic do_cmd(input logic [2:0] op);
        wb_write(ADDR_CMD, 32'(op));
        case (op)
            OP_TW_MUL:         m_twiddle = ref_mont(m_twiddle, m_omega[m_oidx], m_prime);
            OP_OMEGA_SQR:      m_omega[m_oidx] = ref_mont(m_omega[m_oidx], m_omega[m_oidx],
                                                          m_prime);
            OP_PSI_FROM_OMEGA: m_psi[m_pidx] = m_omega[m_oidx];
            OP_TW_FROM_PSI:    m_twiddle = m_psi[m_pidx];
            OP_TW_NEGATE:      m_twiddle = m_prime - m_twiddle;
            OP_OMEGA_IDX_INC:  m_oidx = m_oidx + 3'd1;
            OP_PSI_IDX_INC:    m_pidx = m_pidx + 3'd1;
            default:           m_oidx = m_oidx;
        endcase
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (hung)
            return;
        if (exp !== act) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            err_total++;
            test_errs++;
        end
    endtask

    task automatic check_read(input string name, input logic [4:0] adr);
        logic [31:0] rd;
        wb_read(adr, rd);
        check_value($sformatf("%s @%0d", name, adr), exp_read(adr), rd);
    endtask

    task automatic check_roots(input string name);
        check_value({name, " twiddle_o"}, m_twiddle, twiddle_o);
        check_value({name, " omega_o"}, m_omega[m_oidx], omega_o);
        check_value({name, " psi_o"}, m_psi[m_pidx], psi_o);
        check_value({name, " prime_o"}, m_prime, prime_o);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errs == 0) begin
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    initial begin
        logic [31:0] r;
        rst_n     = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        lcg_state = 32'h67c3c953;
        hung      = 1'b0;
        err_total = 0;
        test_errs = 0;
        tests_run = 0;
        tests_failed = 0;
        m_prime   = '0;
        m_twiddle = '0;
        m_oidx    = '0;
        m_pidx    = '0;
        for (int i = 0; i < 8; i++) begin
            m_omega[i] = '0;
            m_psi[i]   = '0;
        end
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        for (int a = 0; a < 32; a++)
            check_read("reset_values", 5'(a));
        check_roots("reset_values");
        end_test("reset_values");

        reg_write(ADDR_PRIME, next_rand());
        reg_write(ADDR_TWIDDLE, next_rand());
        reg_write(ADDR_OMEGA_IDX, 32'd5);
        reg_write(ADDR_PSI_IDX, 32'd2);
        for (int i = 0; i < 8; i++) begin
            reg_write(5'(ADDR_OMEGA_BASE + i), next_rand());
            reg_write(5'(ADDR_PSI_BASE + i), next_rand());
        end
        for (int a = 0; a < 32; a++)
            check_read("write_readback", 5'(a));
        check_roots("write_readback");
        end_test("write_readback");

        // Operands below an odd prime
        reg_write(ADDR_PRIME, rand_prime());
        reg_write(ADDR_TWIDDLE, next_rand() % m_prime);
        for (int i = 0; i < 8; i++) begin
            reg_write(5'(ADDR_OMEGA_BASE + i), next_rand() % m_prime);
            reg_write(5'(ADDR_PSI_BASE + i), next_rand() % m_prime);
        end
        reg_write(ADDR_OMEGA_IDX, 32'd3);
        repeat (2) begin
            do_cmd(OP_TW_MUL);
            check_roots("twiddle_mul");
            check_read("twiddle_mul", ADDR_TWIDDLE);
        end
        end_test("twiddle_mul");

        do_cmd(OP_OMEGA_SQR);
        for (int i = 0; i < 8; i++)
            check_read("omega_square", 5'(ADDR_OMEGA_BASE + i));
        check_roots("omega_square");
        repeat (5) begin
            do_cmd(OP_OMEGA_IDX_INC);
            check_roots("omega_index_inc");
        end
        check_read("omega_index_inc", ADDR_OMEGA_IDX);
        end_test("omega_square_and_index");

        reg_write(ADDR_PSI_IDX, 32'd6);
        do_cmd(OP_PSI_FROM_OMEGA);
        check_read("psi_from_omega", 5'(ADDR_PSI_BASE + 6));
        check_roots("psi_from_omega");
        do_cmd(OP_TW_FROM_PSI);
        check_roots("twiddle_from_psi");
        repeat (2) begin
            do_cmd(OP_PSI_IDX_INC);
            check_roots("psi_index_inc");
        end
        do_cmd(OP_TW_FROM_PSI);
        check_roots("twiddle_from_psi");
        check_read("twiddle_from_psi", ADDR_TWIDDLE);
        end_test("psi_operations");

        do_cmd(OP_TW_NEGATE);
        check_read("twiddle_negate", ADDR_TWIDDLE);
        check_roots("twiddle_negate");
        reg_write(ADDR_TWIDDLE, 32'd0);
        do_cmd(OP_TW_NEGATE);
        check_value("negate_zero", m_prime, twiddle_o);
        end_test("twiddle_negate");

        for (int n = 0; n < RAND_STEPS; n++) begin
            r = next_rand();
            case (r[31:28] % 4'd10)
                4'd6:    reg_write(ADDR_TWIDDLE, next_rand() % m_prime);
                4'd7:    reg_write(5'(ADDR_OMEGA_BASE + r[2:0]), next_rand() % m_prime);
                4'd8:    reg_write(5'(ADDR_PSI_BASE + r[2:0]), next_rand() % m_prime);
                4'd9:    reg_write(r[4] ? ADDR_PSI_IDX : ADDR_OMEGA_IDX, next_rand());
                default: do_cmd(r[10:8]);
            endcase
            check_read("random_run", r[20:16]);
            check_roots("random_run");
        end
        end_test("random_run");

        $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_total);
        if (err_total == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== twiddle_ctrl_fsm.sv ====
`timescale 1ns/10ps
// ------------------------------
// Wishbone classic slave and
// operation sequencer
// ------------------------------
module twiddle_ctrl_fsm
    import twiddle_pkg::*;
#(
    parameter int DATA_W    = twiddle_pkg::DATA_W,
    parameter int NUM_ROOTS = twiddle_pkg::NUM_ROOTS
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              wb_cyc_i,
    input  logic              wb_stb_i,
    input  logic              wb_we_i,
    input  logic [ADDR_W-1:0] wb_adr_i,
    input  logic [31:0]       wb_dat_i,
    output logic [31:0]       wb_dat_o,
    output logic              wb_ack_o,
    twiddle_ctrl_if.ctrl      ctrl_o,
    output logic              mul_start_o,
    output logic              mul_square_o,
    input  logic              mul_done_i,
    input  logic [DATA_W-1:0] mul_result_i
);

    ctrl_state_e       state_q;
    tw_op_e            op_in;
    tw_op_e            op_q;
    logic              accept;
    logic              adr_valid;
    logic              cmd_wr;
    logic              mul_op;
    logic              ack_q;
    logic              commit_q;
    logic [DATA_W-1:0] mul_result_q;
    logic [DATA_W-1:0] rd_or;
    logic [31:0]       dat_q;

    // New access only taken in idle
    assign accept = (state_q == ST_IDLE) && wb_cyc_i && wb_stb_i;

    assign adr_valid = (wb_adr_i <= ADDR_CMD)
        || (wb_adr_i >= ADDR_OMEGA_BASE && wb_adr_i < ADDR_OMEGA_BASE + NUM_ROOTS)
        || (wb_adr_i >= ADDR_PSI_BASE && wb_adr_i < ADDR_PSI_BASE + NUM_ROOTS);

    assign cmd_wr = accept && wb_we_i && (wb_adr_i == ADDR_CMD);
    assign op_in  = tw_op_e'(wb_dat_i[2:0]);
    assign mul_op = (op_in == OP_TW_MUL) || (op_in == OP_OMEGA_SQR);

    assign mul_start_o  = cmd_wr && mul_op;
    assign mul_square_o = (op_in == OP_OMEGA_SQR);

    assign ctrl_o.wr_en      = accept && wb_we_i && adr_valid && (wb_adr_i != ADDR_CMD);
    assign ctrl_o.addr       = wb_adr_i;
    assign ctrl_o.wdata      = DATA_W'(wb_dat_i);
    // Multiply ops commit with the delayed ack
    assign ctrl_o.op_commit  = (cmd_wr && !mul_op) || commit_q;
    assign ctrl_o.op         = commit_q ? op_q : op_in;
    assign ctrl_o.mul_result = mul_result_q;

    assign rd_or = ctrl_o.rd_regs | ctrl_o.rd_table | ctrl_o.rd_idx;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= ST_IDLE;
            ack_q    <= 1'b0;
            commit_q <= 1'b0;
        end else begin
            ack_q    <= 1'b0;
            commit_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (mul_start_o) begin
                        state_q <= ST_MUL;
                    end else if (accept) begin
                        state_q <= ST_ACK;
                        ack_q   <= 1'b1;
                    end
                end
                ST_MUL: begin
                    if (mul_done_i) begin
                        state_q  <= ST_ACK;
                        ack_q    <= 1'b1;
                        commit_q <= 1'b1;
                    end
                end
                // Master still holds stb here
                ST_ACK: state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (mul_start_o) begin
            op_q <= op_in;
        end
        if (mul_done_i) begin
            mul_result_q <= mul_result_i;
        end
        if (accept) begin
            dat_q <= wb_we_i ? '0 : 32'(rd_or);
        end
    end

    assign wb_ack_o = ack_q;
    assign wb_dat_o = dat_q;

    a_done_only_in_mul: assert property (
        @(posedge clk_i) disable iff (!rst_ni) mul_done_i |-> state_q == ST_MUL
    );

endmodule

// ==== twiddle_ctrl_if.sv ====
`timescale 1ns/10ps
// ------------------------------
// Controller to data-path bundle
// ------------------------------
interface twiddle_ctrl_if
    import twiddle_pkg::*;
#(
    parameter int DATA_W = twiddle_pkg::DATA_W
) ();

    // Decoded bus write, one cycle
    logic              wr_en;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;

    // Operation strobe
    logic              op_commit;
    tw_op_e            op;
    logic [DATA_W-1:0] mul_result;

    // Read data, zero outside own range
    logic [DATA_W-1:0] rd_regs;
    logic [DATA_W-1:0] rd_table;
    logic [DATA_W-1:0] rd_idx;

    modport ctrl (
        output wr_en, addr, wdata, op_commit, op, mul_result,
        input  rd_regs, rd_table, rd_idx
    );

    modport regs (
        input  wr_en, addr, wdata, op_commit, op, mul_result,
        output rd_regs
    );

    // Named tbl since table is a reserved word
    modport tbl (
        input  wr_en, addr, wdata, op_commit, op, mul_result,
        output rd_table
    );

    modport idx (
        input  wr_en, addr, wdata, op_commit, op, mul_result,
        output rd_idx
    );

endinterface

// ==== twiddle_pkg.sv ====
// ------------------------------
// Twiddle unit package
// Widths, register map, opcodes
// ------------------------------
package twiddle_pkg;

    localparam int DATA_W    = 32;
    localparam int NUM_ROOTS = 8;
    localparam int IDX_W     = 3;
    localparam int ADDR_W    = 5;

    // Word addresses on the Wishbone bus
    typedef enum logic [ADDR_W-1:0] {
        ADDR_PRIME      = 5'd0,
        ADDR_TWIDDLE    = 5'd1,
        ADDR_OMEGA_IDX  = 5'd2,
        ADDR_PSI_IDX    = 5'd3,
        ADDR_CMD        = 5'd4,
        ADDR_OMEGA_BASE = 5'd8,
        ADDR_PSI_BASE   = 5'd16
    } reg_addr_e;

    // Opcodes written to ADDR_CMD, 7 is a no-op
    typedef enum logic [2:0] {
        OP_TW_MUL         = 3'd0,
        OP_OMEGA_SQR      = 3'd1,
        OP_PSI_FROM_OMEGA = 3'd2,
        OP_TW_FROM_PSI    = 3'd3,
        OP_TW_NEGATE      = 3'd4,
        OP_OMEGA_IDX_INC  = 3'd5,
        OP_PSI_IDX_INC    = 3'd6
    } tw_op_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MUL,
        ST_ACK
    } ctrl_state_e;

endpackage

// ==== twiddle_regs.sv ====
`timescale 1ns/10ps
// ------------------------------
// Prime and twiddle registers
// ------------------------------
module twiddle_regs
    import twiddle_pkg::*;
#(
    parameter int DATA_W = twiddle_pkg::DATA_W
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    twiddle_ctrl_if.regs      ctrl_i,
    input  logic [DATA_W-1:0] psi_i,
    output logic [DATA_W-1:0] prime_o,
    output logic [DATA_W-1:0] twiddle_o
);

    logic [DATA_W-1:0] prime_q;
    logic [DATA_W-1:0] twiddle_q;
    logic [DATA_W-1:0] twiddle_d;
    logic              twiddle_we;

    // Next twiddle value
    always_comb begin
        twiddle_we = 1'b1;
        twiddle_d  = ctrl_i.wdata;
        if (ctrl_i.wr_en && ctrl_i.addr == ADDR_TWIDDLE) begin
            twiddle_d = ctrl_i.wdata;
        end else if (ctrl_i.op_commit && ctrl_i.op == OP_TW_MUL) begin
            twiddle_d = ctrl_i.mul_result;
        end else if (ctrl_i.op_commit && ctrl_i.op == OP_TW_FROM_PSI) begin
            twiddle_d = psi_i;
        end else if (ctrl_i.op_commit && ctrl_i.op == OP_TW_NEGATE) begin
            // Zero twiddle negates to the prime itself
            twiddle_d = prime_q - twiddle_q;
        end else begin
            twiddle_we = 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            prime_q   <= '0;
            twiddle_q <= '0;
        end else begin
            if (ctrl_i.wr_en && ctrl_i.addr == ADDR_PRIME) begin
                prime_q <= ctrl_i.wdata;
            end
            if (twiddle_we) begin
                twiddle_q <= twiddle_d;
            end
        end
    end

    always_comb begin
        ctrl_i.rd_regs = '0;
        if (ctrl_i.addr == ADDR_PRIME) begin
            ctrl_i.rd_regs = prime_q;
        end else if (ctrl_i.addr == ADDR_TWIDDLE) begin
            ctrl_i.rd_regs = twiddle_q;
        end
    end

    assign prime_o   = prime_q;
    assign twiddle_o = twiddle_q;

endmodule

// ==== twiddle_unit.f ====
twiddle_pkg.sv
twiddle_ctrl_if.sv
mont_mul_serial.sv
root_index_counters.sv
root_table.sv
twiddle_regs.sv
twiddle_ctrl_fsm.sv
twiddle_unit_top.sv
tb_twiddle_unit.sv

// ==== twiddle_unit_top.sv ====
`timescale 1ns/10ps
// ------------------------------
// Twiddle register unit, top
// Wishbone slave and root outputs
// ------------------------------
module twiddle_unit_top
    import twiddle_pkg::*;
#(
    parameter int DATA_W    = twiddle_pkg::DATA_W,
    parameter int NUM_ROOTS = twiddle_pkg::NUM_ROOTS
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              wb_cyc_i,
    input  logic              wb_stb_i,
    input  logic              wb_we_i,
    input  logic [ADDR_W-1:0] wb_adr_i,
    input  logic [31:0]       wb_dat_i,
    output logic [31:0]       wb_dat_o,
    output logic              wb_ack_o,
    output logic [DATA_W-1:0] twiddle_o,
    output logic [DATA_W-1:0] omega_o,
    output logic [DATA_W-1:0] psi_o,
    output logic [DATA_W-1:0] prime_o
);

    logic [IDX_W-1:0]  omega_idx;
    logic [IDX_W-1:0]  psi_idx;
    logic              mul_start;
    logic              mul_square;
    logic              mul_done;
    logic [DATA_W-1:0] mul_result;

    twiddle_ctrl_if #(.DATA_W(DATA_W)) ctrl_if ();

    twiddle_ctrl_fsm #(
        .DATA_W   (DATA_W),
        .NUM_ROOTS(NUM_ROOTS)
    ) i_ctrl (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .ctrl_o      (ctrl_if.ctrl),
        .mul_start_o (mul_start),
        .mul_square_o(mul_square),
        .mul_done_i  (mul_done),
        .mul_result_i(mul_result)
    );

    root_index_counters #(.DATA_W(DATA_W)) i_idx (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .ctrl_i     (ctrl_if.idx),
        .omega_idx_o(omega_idx),
        .psi_idx_o  (psi_idx)
    );

    root_table #(
        .DATA_W   (DATA_W),
        .NUM_ROOTS(NUM_ROOTS)
    ) i_table (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .ctrl_i     (ctrl_if.tbl),
        .omega_idx_i(omega_idx),
        .psi_idx_i  (psi_idx),
        .omega_o    (omega_o),
        .psi_o      (psi_o)
    );

    twiddle_regs #(.DATA_W(DATA_W)) i_regs (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .ctrl_i   (ctrl_if.regs),
        .psi_i    (psi_o),
        .prime_o  (prime_o),
        .twiddle_o(twiddle_o)
    );

    mont_mul_serial #(.DATA_W(DATA_W)) i_mul (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .start_i  (mul_start),
        .square_i (mul_square),
        .twiddle_i(twiddle_o),
        .omega_i  (omega_o),
        .prime_i  (prime_o),
        .done_o   (mul_done),
        .result_o (mul_result)
    );

endmodule
